/* project.f */
src/spk_pkg.sv
src/flit_fifo.sv
src/spk_in_decode.sv
src/axon_accum.sv
src/config_regs.sv
src/node_in_top.sv
tests/tb_node_in.sv

/* run_sim.sh */
#!/bin/sh
# build and run the node input stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_node_in -f project.f -o tb_node_in
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_node_in > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    exit 0
fi
exit 1

/* src/axon_accum.sv */
module axon_accum (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            axon_vld,
    input  spk_pkg::ftype_t axon_type,
    input  spk_pkg::sdata_t axon_data,
    input  logic            axon_en,
    output logic            axon_busy,
    input  logic [3:0]      cnt_addr,
    output spk_pkg::cnt_t   cnt_rdata,
    output logic            pkt_vld,
    output spk_pkg::sdata_t pkt_sum
);
    import spk_pkg::*;

    cnt_t                               counters [AXON_N];
    sdata_t                             acc;
    logic [$clog2(BUSY_CYCLES+1)-1:0]   busy_cnt;
    logic                               is_spike;

    assign is_spike  = axon_vld && (axon_type == FT_SPIKE);
    assign cnt_rdata = counters[cnt_addr];
    assign axon_busy = (busy_cnt != '0);

    // --------------------
    // spike counters
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < AXON_N; i++) begin
                counters[i] <= '0;
            end
        end else if (is_spike && axon_en) begin
            // saturate at 255
            if (counters[axon_data[3:0]] != 8'hff) begin
                counters[axon_data[3:0]] <= counters[axon_data[3:0]] + 1'b1;
            end
        end
    end

    // --------------------
    // packet accumulator
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc     <= '0;
            pkt_vld <= 1'b0;
        end else begin
            pkt_vld <= 1'b0;
            if (axon_vld && axon_type == FT_DATA) begin
                acc <= acc + axon_data;
            end else if (axon_vld && axon_type == FT_DATA_END) begin
                acc     <= '0;
                pkt_vld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (axon_vld && axon_type == FT_DATA_END) begin
            pkt_sum <= acc + axon_data;
        end
    end

    // busy window after each accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (axon_vld) begin
            busy_cnt <= $bits(busy_cnt)'(BUSY_CYCLES);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // decoder must honour the busy level
    a_vld_not_busy : assert property (@(posedge clk) disable iff (!rst_n)
        !(axon_vld && axon_busy))
        else $error("axon_accum: axon_vld while busy");

endmodule

/* src/config_regs.sv */
module config_regs (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_we,
    input  spk_pkg::flit_t  cfg_wdata,
    output logic            cfg_credit,
    output logic            rsp_vld,
    output spk_pkg::sdata_t rsp_data,
    output logic            axon_en,
    output logic [3:0]      cnt_addr,
    input  spk_pkg::cnt_t   cnt_rdata
);
    import spk_pkg::*;

    sdata_t     regs [CFG_N];
    ftype_t     ftype;
    logic [3:0] addr;
    sdata_t     payload;

    // --------------------
    // config flit fields
    // --------------------
    assign ftype   = cfg_wdata[FW-1 -: FTW];
    assign addr    = cfg_wdata[27:24];
    assign payload = cfg_wdata[SW-1:0];

    // upper half of the address space maps onto axon counters 0..7
    assign cnt_addr = {1'b0, addr[2:0]};
    assign axon_en  = regs[0][0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs[0] <= sdata_t'(1);
            for (int i = 1; i < CFG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (cfg_we && ftype == FT_WRITE && !addr[3]) begin
            regs[addr[2:0]] <= payload;
        end
    end

    // read response and credit return
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_vld    <= 1'b0;
            cfg_credit <= 1'b0;
        end else begin
            rsp_vld    <= cfg_we && (ftype == FT_READ);
            cfg_credit <= cfg_we;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_we && ftype == FT_READ) begin
            rsp_data <= addr[3] ? sdata_t'(cnt_rdata) : regs[addr[2:0]];
        end
    end

    // a new write must wait for the returned credit
    a_credit_gap : assert property (@(posedge clk) disable iff (!rst_n)
        cfg_credit |=> !cfg_we)
        else $error("config_regs: cfg_we before credit was taken back");

endmodule

/* src/flit_fifo.sv */
module flit_fifo (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wr_en,
    input  logic           rd_en,
    input  spk_pkg::flit_t din,
    output spk_pkg::flit_t dout,
    output logic           empty,
    output logic           full
);
    import spk_pkg::*;

    flit_t              mem [1 << FIFO_AW];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               push;
    logic               pop;

    assign full  = (count == {1'b1, {FIFO_AW{1'b0}}});
    assign empty = (count == '0);
    assign push  = wr_en && !full;
    assign pop   = rd_en && !empty;

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
        if (pop) begin
            dout <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // router credits must keep writes away from a full buffer
    a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && full))
        else $error("flit_fifo: write while full");

    a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_en && empty))
        else $error("flit_fifo: read while empty");

endmodule

/* src/node_in_top.sv */
module node_in_top (
    input  logic            clk,
    input  logic            rst_n,
    input  spk_pkg::flit_t  flit_in,
    input  logic            flit_in_wr,
    output logic            credit_out,
    output logic            pkt_vld,
    output spk_pkg::sdata_t pkt_sum,
    output logic            rsp_vld,
    output spk_pkg::sdata_t rsp_data
);
    import spk_pkg::*;

    flit_t      fifo_dout;
    logic       fifo_empty;
    logic       fifo_pop;
    logic       axon_busy;
    logic       axon_vld;
    ftype_t     axon_type;
    sdata_t     axon_data;
    logic       cfg_credit;
    logic       cfg_we;
    flit_t      cfg_wdata;
    logic       axon_en;
    logic [3:0] cnt_addr;
    cnt_t       cnt_rdata;

    // one router credit per flit leaving the buffer
    assign credit_out = fifo_pop;

    flit_fifo i_flit_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (flit_in_wr),
        .rd_en (fifo_pop),
        .din   (flit_in),
        .dout  (fifo_dout),
        .empty (fifo_empty),
        .full  ()
    );

    spk_in_decode i_spk_in_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_empty (fifo_empty),
        .fifo_dout  (fifo_dout),
        .fifo_pop   (fifo_pop),
        .axon_busy  (axon_busy),
        .axon_vld   (axon_vld),
        .axon_type  (axon_type),
        .axon_data  (axon_data),
        .cfg_credit (cfg_credit),
        .cfg_we     (cfg_we),
        .cfg_wdata  (cfg_wdata)
    );

    axon_accum i_axon_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .axon_vld  (axon_vld),
        .axon_type (axon_type),
        .axon_data (axon_data),
        .axon_en   (axon_en),
        .axon_busy (axon_busy),
        .cnt_addr  (cnt_addr),
        .cnt_rdata (cnt_rdata),
        .pkt_vld   (pkt_vld),
        .pkt_sum   (pkt_sum)
    );

    config_regs i_config_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_we     (cfg_we),
        .cfg_wdata  (cfg_wdata),
        .cfg_credit (cfg_credit),
        .rsp_vld    (rsp_vld),
        .rsp_data   (rsp_data),
        .axon_en    (axon_en),
        .cnt_addr   (cnt_addr),
        .cnt_rdata  (cnt_rdata)
    );

endmodule

/* src/spk_in_decode.sv */
module spk_in_decode (
    input  logic            clk,
    input  logic            rst_n,
    // flit FIFO
    input  logic            fifo_empty,
    input  spk_pkg::flit_t  fifo_dout,
    output logic            fifo_pop,
    // axon
    input  logic            axon_busy,
    output logic            axon_vld,
    output spk_pkg::ftype_t axon_type,
    output spk_pkg::sdata_t axon_data,
    // config
    input  logic            cfg_credit,
    output logic            cfg_we,
    output spk_pkg::flit_t  cfg_wdata
);
    import spk_pkg::*;

    dec_state_t cs;
    dec_state_t ns;
    ftype_t     ftype;
    logic       send_axon;
    logic       send_config;
    logic       credit_ok;

    // --------------------
    // flit classification
    // --------------------
    assign ftype = fifo_dout[FW-1 -: FTW];

    always_comb begin
        send_axon   = 1'b0;
        send_config = 1'b0;
        case (ftype)
            FT_SPIKE, FT_DATA, FT_DATA_END: send_axon   = 1'b1;
            FT_WRITE, FT_READ:              send_config = 1'b1;
            default:                        ;
        endcase
    end

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs <= IDLE;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = cs;
        case (cs)
            IDLE: begin
                ns = fifo_empty ? IDLE : S_WAIT;
            end
            S_WAIT: begin
                if (send_axon) begin
                    ns = axon_busy ? S_WAIT : S_AXON;
                end else if (send_config) begin
                    ns = credit_ok ? S_CONFIG : S_WAIT;
                end else begin
                    // unknown type, drop the flit
                    ns = IDLE;
                end
            end
            S_AXON, S_CONFIG: begin
                ns = fifo_empty ? IDLE : S_WAIT;
            end
            default: begin
                ns = IDLE;
            end
        endcase
    end

    // pop on entry to S_WAIT, flit is on dout one cycle later
    assign fifo_pop = (ns == S_WAIT) && (cs != S_WAIT);
    assign axon_vld = (cs == S_AXON);
    assign cfg_we   = (cs == S_CONFIG);

    // output payload captured on the S_WAIT exit
    always_ff @(posedge clk) begin
        if (cs == S_WAIT && ns == S_AXON) begin
            axon_type <= ftype;
            axon_data <= fifo_dout[SW-1:0];
        end
        if (cs == S_WAIT && ns == S_CONFIG) begin
            cfg_wdata <= fifo_dout;
        end
    end

    // one-deep config credit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_ok <= 1'b1;
        end else if (cfg_credit) begin
            credit_ok <= 1'b1;
        end else if (cfg_we) begin
            credit_ok <= 1'b0;
        end
    end

    a_one_target : assert property (@(posedge clk) disable iff (!rst_n)
        !(axon_vld && cfg_we))
        else $error("spk_in_decode: axon and config dispatch together");

endmodule

/* src/spk_pkg.sv */
package spk_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int FW          = 59;
    localparam int FTW         = 3;
    localparam int SW          = 24;
    localparam int FIFO_AW     = 4;
    localparam int AXON_N      = 16;
    localparam int CFG_N       = 8;

    // axon block stays busy this many cycles after each accept
    localparam int BUSY_CYCLES = 2;

    // --------------------
    // flit fields
    // --------------------
    // type in the top bits, payload in the bottom 24
    // config flits carry the register address in bits 27..24
    typedef logic [FW-1:0]  flit_t;
    typedef logic [FTW-1:0] ftype_t;
    typedef logic [SW-1:0]  sdata_t;

    // saturating spike count per axon
    typedef logic [7:0]     cnt_t;

    // flit type codes
    localparam ftype_t FT_SPIKE    = 3'b000;
    localparam ftype_t FT_DATA     = 3'b001;
    localparam ftype_t FT_DATA_END = 3'b010;
    localparam ftype_t FT_WRITE    = 3'b110;
    localparam ftype_t FT_READ     = 3'b111;

    // --------------------
    // decoder FSM
    // --------------------
    typedef enum logic [1:0] {
        IDLE,
        S_WAIT,
        S_AXON,
        S_CONFIG
    } dec_state_t;

endpackage

/* tests/tb_node_in.sv */
module tb_node_in;
    timeunit 1ns;
    timeprecision 100ps;
    import spk_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int ROUTER_CRED  = 16;
    // flits over all tests, with some slack
    localparam int FLIT_BUDGET  = 400;
    localparam int LIMIT_CYCLES = FLIT_BUDGET * 10 + 500;

    logic        clk = 1'b0;
    logic        rst_n;
    flit_t       flit_in;
    logic        flit_in_wr;
    logic        credit_out;
    logic        pkt_vld;
    sdata_t      pkt_sum;
    logic        rsp_vld;
    sdata_t      rsp_data;

    // reference model state
    cnt_t        cnt_m [AXON_N];
    sdata_t      regs_m [CFG_N];
    sdata_t      acc_m;
    sdata_t      exp_rsp [$];
    sdata_t      exp_pkt [$];
    int          rsp_wr;
    int          rsp_rd;
    int          pkt_wr;
    int          pkt_rd;
    int          n_sent;
    int          n_credit;
    logic [31:0] lfsr;

    node_in_top i_node_in_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .flit_in    (flit_in),
        .flit_in_wr (flit_in_wr),
        .credit_out (credit_out),
        .pkt_vld    (pkt_vld),
        .pkt_sum    (pkt_sum),
        .rsp_vld    (rsp_vld),
        .rsp_data   (rsp_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // helpers
    // --------------------
    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            r    = {r[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], fb};
        end
        return r;
    endfunction

    function automatic flit_t make_flit(input ftype_t t, input logic [3:0] addr,
                                        input sdata_t data);
        flit_t f;
        f              = '0;
        f[FW-1 -: FTW] = t;
        f[27:24]       = addr;
        f[SW-1:0]      = data;
        return f;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string sig, input sdata_t want, input sdata_t got);
        abort_run($sformatf("error at %0t ns: %s expected %h, got %h",
                            $time, sig, want, got));
    endtask

    // router side, one flit per falling edge while credit lasts
    task automatic send_flit(input flit_t f);
        while (n_sent - n_credit >= ROUTER_CRED) begin
            @(negedge clk);
        end
        flit_in    = f;
        flit_in_wr = 1'b1;
        n_sent++;
        @(negedge clk);
        flit_in_wr = 1'b0;
    endtask

    // --------------------
    // model updates in flit order
    // --------------------
    task automatic spike(input logic [3:0] axon);
        if (regs_m[0][0] && cnt_m[axon] != 8'hff) begin
            cnt_m[axon] = cnt_m[axon] + 8'd1;
        end
        send_flit(make_flit(FT_SPIKE, 4'h0, {20'(rand_bits(20)), axon}));
    endtask

    task automatic data_flit(input sdata_t val, input logic last);
        if (last) begin
            exp_pkt.push_back(acc_m + val);
            pkt_wr++;
            acc_m = '0;
        end else begin
            acc_m = acc_m + val;
        end
        send_flit(make_flit(last ? FT_DATA_END : FT_DATA, 4'h0, val));
    endtask

    task automatic cfg_write(input logic [3:0] addr, input sdata_t val);
        // upper addresses are not writable
        if (!addr[3]) begin
            regs_m[addr[2:0]] = val;
        end
        send_flit(make_flit(FT_WRITE, addr, val));
    endtask

    task automatic cfg_read(input logic [3:0] addr);
        sdata_t want;
        want = addr[3] ? {16'h0, cnt_m[addr - 4'd8]} : regs_m[addr[2:0]];
        exp_rsp.push_back(want);
        rsp_wr++;
        send_flit(make_flit(FT_READ, addr, sdata_t'(rand_bits(24))));
    endtask

    // all credits back and every expected pulse seen
    task automatic drain();
        while (n_credit != n_sent || rsp_rd != rsp_wr || pkt_rd != pkt_wr) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    // --------------------
    // checkers
    // --------------------
    always @(posedge clk) begin
        if (credit_out) begin
            n_credit <= n_credit + 1;
        end
        if (rsp_vld) begin
            rsp_rd <= rsp_rd + 1;
        end
        if (pkt_vld) begin
            pkt_rd <= pkt_rd + 1;
        end
    end

    a_reset_quiet : assert property (@(posedge clk)
        !rst_n |-> (!credit_out && !pkt_vld && !rsp_vld))
        else abort_run("outputs active during reset");

    a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
        (n_credit <= n_sent) && (n_sent - n_credit <= ROUTER_CRED))
        else abort_run($sformatf("router credit out of range, sent %0d returned %0d",
                                 n_sent, n_credit));

    a_rsp_expected : assert property (@(posedge clk) disable iff (!rst_n)
        rsp_vld |-> (rsp_rd < rsp_wr))
        else abort_run("read response with no read outstanding");

    a_rsp_data : assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_vld && rsp_rd < rsp_wr) |-> (rsp_data == exp_rsp[rsp_rd]))
        else value_error("rsp_data", exp_rsp[$sampled(rsp_rd)], $sampled(rsp_data));

    a_pkt_expected : assert property (@(posedge clk) disable iff (!rst_n)
        pkt_vld |-> (pkt_rd < pkt_wr))
        else abort_run("packet sum with no DATA_END outstanding");

    a_pkt_sum : assert property (@(posedge clk) disable iff (!rst_n)
        (pkt_vld && pkt_rd < pkt_wr) |-> (pkt_sum == exp_pkt[pkt_rd]))
        else value_error("pkt_sum", exp_pkt[$sampled(pkt_rd)], $sampled(pkt_sum));

    // --------------------
    // stimulus
    // --------------------
    initial begin
        sdata_t     v;
        logic [2:0] ax;
        logic [2:0] kind;
        lfsr       = 32'h144c;
        rst_n      = 1'b0;
        flit_in    = '0;
        flit_in_wr = 1'b0;
        acc_m      = '0;
        for (int i = 0; i < AXON_N; i++) begin
            cnt_m[i] = '0;
        end
        for (int i = 0; i < CFG_N; i++) begin
            regs_m[i] = '0;
        end
        regs_m[0] = sdata_t'(1);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // register file, reset value then write and read back
        cfg_read(4'd0);
        for (int r = 1; r < CFG_N; r++) begin
            v = sdata_t'(rand_bits(24));
            cfg_write(4'(r), v);
            cfg_read(4'(r));
        end
        drain();

        // random spikes, then saturation on axon 3
        repeat (40) begin
            ax = 3'(rand_bits(3));
            spike({1'b0, ax});
        end
        for (int a = 8; a < 16; a++) begin
            cfg_read(4'(a));
        end
        repeat (260) spike(4'd3);
        cfg_read(4'd11);
        drain();

        // counting off and back on
        cfg_write(4'd0, '0);
        repeat (10) begin
            ax = 3'(rand_bits(3));
            spike({1'b0, ax});
        end
        for (int a = 8; a < 16; a++) begin
            cfg_read(4'(a));
        end
        cfg_write(4'd0, sdata_t'(1));
        repeat (5) spike(4'd5);
        cfg_read(4'd13);
        drain();

        // two packets, the second starts from zero
        repeat (5) data_flit(sdata_t'(rand_bits(24)), 1'b0);
        data_flit(sdata_t'(rand_bits(24)), 1'b1);
        repeat (3) data_flit(sdata_t'(rand_bits(24)), 1'b0);
        data_flit(sdata_t'(rand_bits(24)), 1'b1);
        drain();

        // back-to-back burst on a full set of router credits
        for (int i = 0; i < 16; i++) begin
            kind = 3'(rand_bits(3));
            case (kind)
                3'd0, 3'd1: spike({1'b0, 3'(rand_bits(3))});
                3'd2, 3'd3: data_flit(sdata_t'(rand_bits(24)), 1'b0);
                3'd4:       data_flit(sdata_t'(rand_bits(24)), 1'b1);
                3'd5:       cfg_write(4'(rand_bits(4)) | 4'd1, sdata_t'(rand_bits(24)));
                3'd6:       cfg_read({1'b0, 3'(rand_bits(3))});
                3'd7:       cfg_read({1'b1, 3'(rand_bits(3))});
            endcase
        end
        for (int a = 8; a < 16; a++) begin
            cfg_read(4'(a));
        end
        drain();

        if (n_credit == n_sent && rsp_rd == rsp_wr && pkt_rd == pkt_wr) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("flit accounting off, sent %0d credits %0d", n_sent, n_credit));
        end
    end

    // watchdog
    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        abort_run($sformatf("timeout: %0d flits sent, %0d credits back, %0d of %0d reads answered",
                            n_sent, n_credit, rsp_rd, rsp_wr));
    end

endmodule
